//--- verilog/dac_pkg.sv
/* AD5601 DAC controller shared definitions */

`default_nettype none

package dac_pkg;

    //////////////////////////////
    // widths and word layout

    localparam int WORD_BITS = 16;
    localparam int LEVEL_BITS = 8;
    localparam int ADDR_BITS = 2;

    // mode [15:14], data [13:6], reserved [5:0]
    typedef logic [WORD_BITS-1:0] dac_word_t;
    typedef logic [LEVEL_BITS-1:0] level_code_t;
    typedef logic [ADDR_BITS-1:0] reg_addr_t;
    typedef logic [4:0] bit_count_t;

    localparam int DATA_LSB = 6;

    //////////////////////////////
    // register map

    localparam reg_addr_t ADDR_VERSION = 2'd0;
    localparam reg_addr_t ADDR_DAC_WORD = 2'd1;
    localparam reg_addr_t ADDR_CTRL = 2'd2;

    localparam dac_word_t MODULE_VERSION = 16'd1;

    // normal mode, code 0x55
    localparam dac_word_t DAC_DEFAULT_WORD = 16'h1540;

    //////////////////////////////
    // serial timing

    localparam int FRAME_BITS = 16;
    localparam int SCLK_HALF_CYCLES = 4;
    localparam int PRESCALE_BITS = $clog2(SCLK_HALF_CYCLES);

    typedef enum logic [1:0] {
        RESET_FRAME,
        IDLE,
        SENDING
    } seq_state_t;

endpackage

`default_nettype wire

//--- verilog/dac_frame_if.sv
/* DAC frame request link */

`timescale 1ns/100ps
`default_nettype none

interface dac_frame_if;
    import dac_pkg::*;

    // one-cycle request, word held stable with it
    logic start;
    dac_word_t word;

    // shifter status back to the sequencer
    logic done;
    logic busy;

    modport seq (
        output start,
        output word,
        input done,
        input busy
    );

    modport shifter (
        input start,
        input word,
        output done,
        output busy
    );

endinterface

`default_nettype wire

//--- verilog/dac_reg_map.sv
/* DAC register map */

`timescale 1ns/100ps
`default_nettype none

module dac_reg_map (
    input logic clk,
    input logic peripheral_sreset,

    // host register access
    input dac_pkg::reg_addr_t reg_addr,
    input dac_pkg::dac_word_t reg_wdata,
    input logic reg_wr,
    input logic reg_rd,
    output dac_pkg::dac_word_t reg_rdata,
    output logic reg_rvalid,

    // path select and gain source
    input logic en_mmi_ctrl,
    input dac_pkg::level_code_t level_code,
    input logic level_stb,

    // toward the sequencer
    output dac_pkg::dac_word_t dac_word,
    output logic update_req
);
    import dac_pkg::*;

    logic wr_accept;
    logic level_accept;
    dac_word_t level_word;
    dac_word_t ctrl_word;
    dac_word_t read_mux;

    //////////////////////////////
    // write arbitration

    // en_mmi_ctrl picks exactly one owner of the word
    assign wr_accept = reg_wr && (reg_addr == ADDR_DAC_WORD) && en_mmi_ctrl;
    assign level_accept = level_stb && !en_mmi_ctrl;

    // level code only replaces the data field
    always_comb begin
        level_word = dac_word;
        level_word[DATA_LSB +: LEVEL_BITS] = level_code;
    end

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            dac_word <= DAC_DEFAULT_WORD;
            update_req <= 1'b0;
        end else begin
            update_req <= wr_accept || level_accept;
            if (wr_accept) begin
                dac_word <= reg_wdata;
            end else if (level_accept) begin
                dac_word <= level_word;
            end
        end
    end

    //////////////////////////////
    // read path

    always_comb begin
        ctrl_word = '0;
        ctrl_word[0] = en_mmi_ctrl;
    end

    always_comb begin
        case (reg_addr)
            ADDR_VERSION: read_mux = MODULE_VERSION;
            ADDR_DAC_WORD: read_mux = dac_word;
            ADDR_CTRL: read_mux = ctrl_word;
            // address 3 is not mapped
            default: read_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= read_mux;
        end
    end

    // host issues single-cycle read strobes
    a_rvalid_pulse : assert property (
        @(posedge clk) disable iff (peripheral_sreset)
        reg_rvalid |=> !reg_rvalid
    );

endmodule

`default_nettype wire

//--- verilog/dac_update_sequencer.sv
/* DAC update sequencer */

`timescale 1ns/100ps
`default_nettype none

module dac_update_sequencer (
    input logic clk,
    input logic peripheral_sreset,

    input logic update_req,
    input dac_pkg::dac_word_t dac_word,

    dac_frame_if.seq frame,

    output logic dac_updated_stb,
    output logic init_done
);
    import dac_pkg::*;

    seq_state_t state_q;
    logic pending_q;
    logic issue;
    logic start_q;
    dac_word_t word_q;

    assign frame.start = start_q;
    assign frame.word = word_q;

    // decide whether a frame goes out on this edge
    always_comb begin
        case (state_q)
            RESET_FRAME: issue = 1'b1;
            IDLE: issue = update_req && !frame.busy;
            // coalesced updates restart right at done
            SENDING: issue = frame.done && (pending_q || update_req);
            default: issue = 1'b0;
        endcase
    end

    //////////////////////////////
    // state machine

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            state_q <= RESET_FRAME;
            pending_q <= 1'b0;
            start_q <= 1'b0;
            dac_updated_stb <= 1'b0;
            init_done <= 1'b0;
        end else begin
            start_q <= issue;
            dac_updated_stb <= 1'b0;
            case (state_q)
                RESET_FRAME: begin
                    state_q <= SENDING;
                    pending_q <= update_req;
                end
                IDLE: begin
                    if (update_req) begin
                        state_q <= SENDING;
                        // shifter still draining, hold the request
                        pending_q <= frame.busy;
                    end
                end
                SENDING: begin
                    if (frame.done) begin
                        dac_updated_stb <= 1'b1;
                        init_done <= 1'b1;
                        pending_q <= 1'b0;
                        if (!issue) begin
                            state_q <= IDLE;
                        end
                    end else if (update_req) begin
                        pending_q <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // newest register value at the moment of issue
    always_ff @(posedge clk) begin
        if (issue) begin
            word_q <= dac_word;
        end
    end

    a_start_not_busy : assert property (
        @(posedge clk) disable iff (peripheral_sreset)
        frame.start |-> !frame.busy
    );

    a_start_single : assert property (
        @(posedge clk) disable iff (peripheral_sreset)
        frame.start |=> !frame.start
    );

endmodule

`default_nettype wire

//--- verilog/sclk_bit_timer.sv
/* sclk and bit timer */

`timescale 1ns/100ps
`default_nettype none

module sclk_bit_timer (
    input logic clk,
    input logic peripheral_sreset,
    input logic run,
    output logic half_tick,
    output logic last_bit,
    output dac_pkg::bit_count_t bit_count
);
    import dac_pkg::*;

    logic [PRESCALE_BITS-1:0] prescale_q;
    // high during the second half of a bit
    logic phase_q;

    assign half_tick = run && (prescale_q == PRESCALE_BITS'(SCLK_HALF_CYCLES - 1));
    assign last_bit = (bit_count == bit_count_t'(FRAME_BITS - 1));

    always_ff @(posedge clk) begin
        if (peripheral_sreset || !run) begin
            prescale_q <= '0;
            phase_q <= 1'b0;
            bit_count <= '0;
        end else if (half_tick) begin
            prescale_q <= '0;
            phase_q <= !phase_q;
            // a bit completes every second tick
            if (phase_q) begin
                bit_count <= bit_count + 1'b1;
            end
        end else begin
            prescale_q <= prescale_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dac_serial_shifter.sv
/* DAC serial shifter */

`timescale 1ns/100ps
`default_nettype none

module dac_serial_shifter (
    input logic clk,
    input logic peripheral_sreset,

    dac_frame_if.shifter frame,

    input logic half_tick,
    input logic last_bit,
    input dac_pkg::bit_count_t bit_count,
    output logic run,

    output logic sync_n,
    output logic sclk,
    output logic sdin
);
    import dac_pkg::*;

    logic busy_q;
    logic done_q;
    logic load;
    logic fall_tick;
    logic rise_tick;
    dac_word_t shift_q;

    assign frame.busy = busy_q;
    assign frame.done = done_q;
    assign run = busy_q;

    assign load = frame.start && !busy_q;
    // sclk level tells which half period just ended
    assign fall_tick = half_tick && sclk;
    assign rise_tick = half_tick && !sclk;

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            sync_n <= 1'b1;
            sclk <= 1'b1;
            sdin <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                busy_q <= 1'b1;
                sync_n <= 1'b0;
                sdin <= frame.word[FRAME_BITS-1];
            end else if (fall_tick) begin
                sclk <= 1'b0;
            end else if (rise_tick) begin
                sclk <= 1'b1;
                if (last_bit) begin
                    // frame over after the last low half period
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                    sync_n <= 1'b1;
                    sdin <= 1'b0;
                end else begin
                    sdin <= shift_q[FRAME_BITS-2];
                end
            end
        end
    end

    // next bit moves up on every rising sclk
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= frame.word;
        end else if (rise_tick) begin
            shift_q <= shift_q << 1;
        end
    end

    // DAC samples on falling sclk, data must hold through the low phase
    a_sdin_stable : assert property (
        @(posedge clk) disable iff (peripheral_sreset)
        (!sync_n && !sclk) ##1 (!sync_n && !sclk) |-> $stable(sdin)
    );

    a_count_in_frame : assert property (
        @(posedge clk) disable iff (peripheral_sreset)
        !sync_n |-> (bit_count < bit_count_t'(FRAME_BITS))
    );

endmodule

`default_nettype wire

//--- verilog/dac_ad5601_top.sv
/* AD5601 DAC controller top */

`timescale 1ns/100ps
`default_nettype none

module dac_ad5601_top (
    input logic clk,
    input logic peripheral_sreset,

    input dac_pkg::reg_addr_t reg_addr,
    input dac_pkg::dac_word_t reg_wdata,
    input logic reg_wr,
    input logic reg_rd,
    output dac_pkg::dac_word_t reg_rdata,
    output logic reg_rvalid,

    input logic en_mmi_ctrl,
    input dac_pkg::level_code_t level_code,
    input logic level_stb,

    output logic dac_updated_stb,
    output logic init_done,

    // AD5601 serial pins
    output logic sync_n,
    output logic sclk,
    output logic sdin
);
    import dac_pkg::*;

    dac_word_t dac_word;
    logic update_req;
    logic run;
    logic half_tick;
    logic last_bit;
    bit_count_t bit_count;

    dac_frame_if frame_if ();

    dac_reg_map u_reg_map (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .reg_addr          (reg_addr),
        .reg_wdata         (reg_wdata),
        .reg_wr            (reg_wr),
        .reg_rd            (reg_rd),
        .reg_rdata         (reg_rdata),
        .reg_rvalid        (reg_rvalid),
        .en_mmi_ctrl       (en_mmi_ctrl),
        .level_code        (level_code),
        .level_stb         (level_stb),
        .dac_word          (dac_word),
        .update_req        (update_req)
    );

    dac_update_sequencer u_sequencer (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .update_req        (update_req),
        .dac_word          (dac_word),
        .frame             (frame_if.seq),
        .dac_updated_stb   (dac_updated_stb),
        .init_done         (init_done)
    );

    sclk_bit_timer u_timer (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .run               (run),
        .half_tick         (half_tick),
        .last_bit          (last_bit),
        .bit_count         (bit_count)
    );

    dac_serial_shifter u_shifter (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .frame             (frame_if.shifter),
        .half_tick         (half_tick),
        .last_bit          (last_bit),
        .bit_count         (bit_count),
        .run               (run),
        .sync_n            (sync_n),
        .sclk              (sclk),
        .sdin              (sdin)
    );

endmodule

`default_nettype wire

//--- sim/dac_ad5601_tb.sv
/* AD5601 DAC controller testbench */

`timescale 1ns/100ps
`default_nettype none

module dac_ad5601_tb;
    import dac_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_CYCLES = FRAME_BITS * 2 * SCLK_HALF_CYCLES;
    localparam int QUIET_CYCLES = FRAME_CYCLES + 32;
    localparam int CYCLES_PER_OP = 200;
    localparam int BURST_GAP = 6;

    logic clk = 1'b0;
    logic peripheral_sreset;
    reg_addr_t reg_addr;
    dac_word_t reg_wdata;
    logic reg_wr;
    logic reg_rd;
    dac_word_t reg_rdata;
    logic reg_rvalid;
    logic en_mmi_ctrl;
    level_code_t level_code;
    logic level_stb;
    logic dac_updated_stb;
    logic init_done;
    logic sync_n;
    logic sclk;
    logic sdin;

    // one entry per stimulus line
    string op_list[$];
    logic [15:0] arg_a_list[$];
    logic [15:0] arg_b_list[$];
    dac_word_t exp_list[$];
    int nframe_list[$];
    bit ops_loaded = 1'b0;

    dac_word_t frame_q[$];
    dac_word_t shift_word = '0;
    int shift_bits = 0;
    int stb_count = 0;
    int error_count = 0;
    int pass_tests = 0;
    int fail_tests = 0;
    dac_word_t cur_word = DAC_DEFAULT_WORD;

    always begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    dac_ad5601_top DUT (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .reg_addr          (reg_addr),
        .reg_wdata         (reg_wdata),
        .reg_wr            (reg_wr),
        .reg_rd            (reg_rd),
        .reg_rdata         (reg_rdata),
        .reg_rvalid        (reg_rvalid),
        .en_mmi_ctrl       (en_mmi_ctrl),
        .level_code        (level_code),
        .level_stb         (level_stb),
        .dac_updated_stb   (dac_updated_stb),
        .init_done         (init_done),
        .sync_n            (sync_n),
        .sclk              (sclk),
        .sdin              (sdin)
    );

    //////////////////////////////
    // monitors

    // the DAC takes sdin on falling sclk while sync_n is low
    always @(negedge sclk) begin
        if (sync_n === 1'b0) begin
            shift_word = {shift_word[WORD_BITS-2:0], sdin};
            shift_bits = shift_bits + 1;
            if (shift_bits == FRAME_BITS) begin
                frame_q.push_back(shift_word);
                shift_bits = 0;
            end
        end
    end

    always @(negedge clk) begin
        if (dac_updated_stb === 1'b1) begin
            stb_count <= stb_count + 1;
        end
    end

    //////////////////////////////
    // checks and helpers

    task automatic check_word(input string what, input dac_word_t got, input dac_word_t exp);
        if (got !== exp) begin
            $display("ERROR @ %0t: %s: got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR @ %0t: %s: got %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // mode and reserved bits stay while bits 13..6 take the code
    function automatic dac_word_t merge_level(input dac_word_t w, input level_code_t code);
        return {w[15:14], code, w[5:0]};
    endfunction

    task automatic wait_drive_point();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic expect_frames(input int n, input dac_word_t first_exp,
                                 input dac_word_t last_exp, input int frame_base,
                                 input int stb_base);
        int waited;
        waited = 0;
        if (n > 0) begin
            while ((frame_q.size() < frame_base + n || stb_count < stb_base + n)
                   && waited < (n + 1) * (FRAME_CYCLES + 16)) begin
                @(negedge clk);
                waited++;
            end
            if (frame_q.size() < frame_base + n) begin
                $display("timed out at %0t waiting for %0d frame(s)", $time, n);
                error_count++;
            end else begin
                check_word("last frame", frame_q[frame_base + n - 1], last_exp);
                if (n > 1) begin
                    check_word("first frame", frame_q[frame_base], first_exp);
                end
            end
        end
        // any extra frame would complete within this window
        repeat (QUIET_CYCLES) @(negedge clk);
        check_flag("frame count", frame_q.size() == frame_base + n, 1'b1);
        check_flag("updated strobe count", stb_count == stb_base + n, 1'b1);
    endtask

    task automatic read_check(input reg_addr_t addr, input dac_word_t exp);
        wait_drive_point();
        reg_addr = addr;
        reg_rd = 1'b1;
        @(negedge clk);
        check_flag("rvalid before read edge", reg_rvalid, 1'b0);
        wait_drive_point();
        reg_rd = 1'b0;
        @(negedge clk);
        check_flag("rvalid one cycle after read", reg_rvalid, 1'b1);
        check_word("read data", reg_rdata, exp);
        @(negedge clk);
        check_flag("rvalid single pulse", reg_rvalid, 1'b0);
    endtask

    task automatic run_burst(input int count, input level_code_t last_code,
                             input dac_word_t exp, input int n);
        int frame_base;
        int stb_base;
        level_code_t code;
        dac_word_t first_exp;
        frame_base = frame_q.size();
        stb_base = stb_count;
        first_exp = exp;
        for (int i = 0; i < count; i++) begin
            wait_drive_point();
            code = (i == count - 1) ? last_code : level_code_t'($urandom);
            if (i == 0) begin
                first_exp = merge_level(cur_word, code);
            end
            level_code = code;
            level_stb = 1'b1;
            wait_drive_point();
            level_stb = 1'b0;
            repeat (BURST_GAP - 1) wait_drive_point();
        end
        expect_frames(n, first_exp, exp, frame_base, stb_base);
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        int fd;
        int fields;
        int n;
        int errors_before;
        int frame_base;
        int stb_base;
        string line;
        string op;
        logic [15:0] a;
        logic [15:0] b;
        dac_word_t e;

        void'($urandom(32'h3635));
        peripheral_sreset = 1'b1;
        reg_addr = '0;
        reg_wdata = '0;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        en_mmi_ctrl = 1'b0;
        level_code = '0;
        level_stb = 1'b0;

        fd = $fopen("sim/dac_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file sim/dac_stim.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %d", op, a, b, e, n);
                    if (fields == 5) begin
                        op_list.push_back(op);
                        arg_a_list.push_back(a);
                        arg_b_list.push_back(b);
                        exp_list.push_back(e);
                        nframe_list.push_back(n);
                    end
                end
            end
            $fclose(fd);
        end
        if (op_list.size() == 0) begin
            $display("no operations were read from the stimulus file");
            error_count++;
        end
        ops_loaded = 1'b1;

        // idle levels while reset is held
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        errors_before = error_count;
        check_flag("sync_n in reset", sync_n, 1'b1);
        check_flag("sclk in reset", sclk, 1'b1);
        check_flag("sdin in reset", sdin, 1'b0);
        check_flag("init_done in reset", init_done, 1'b0);
        check_flag("rvalid in reset", reg_rvalid, 1'b0);
        check_flag("updated strobe in reset", dac_updated_stb, 1'b0);
        if (error_count == errors_before) begin
            pass_tests++;
            $display("test reset state: pass");
        end else begin
            fail_tests++;
            $display("test reset state: fail");
        end
        wait_drive_point();
        peripheral_sreset = 1'b0;

        foreach (op_list[i]) begin
            errors_before = error_count;
            frame_base = frame_q.size();
            stb_base = stb_count;
            if (op_list[i] == "WAITF") begin
                expect_frames(nframe_list[i], exp_list[i], exp_list[i], frame_base, stb_base);
                check_flag("init_done after frame", init_done, 1'b1);
                cur_word = exp_list[i];
            end else if (op_list[i] == "WRITE") begin
                wait_drive_point();
                reg_addr = arg_a_list[i][ADDR_BITS-1:0];
                reg_wdata = arg_b_list[i];
                reg_wr = 1'b1;
                wait_drive_point();
                reg_wr = 1'b0;
                expect_frames(nframe_list[i], exp_list[i], exp_list[i], frame_base, stb_base);
                if (nframe_list[i] > 0) begin
                    cur_word = exp_list[i];
                end
            end else if (op_list[i] == "LEVEL") begin
                wait_drive_point();
                level_code = arg_a_list[i][LEVEL_BITS-1:0];
                level_stb = 1'b1;
                wait_drive_point();
                level_stb = 1'b0;
                expect_frames(nframe_list[i], exp_list[i], exp_list[i], frame_base, stb_base);
                if (nframe_list[i] > 0) begin
                    cur_word = exp_list[i];
                end
            end else if (op_list[i] == "READ") begin
                read_check(arg_a_list[i][ADDR_BITS-1:0], exp_list[i]);
            end else if (op_list[i] == "SETEN") begin
                wait_drive_point();
                en_mmi_ctrl = arg_a_list[i][0];
            end else if (op_list[i] == "BURST") begin
                run_burst(int'(arg_a_list[i]), arg_b_list[i][LEVEL_BITS-1:0],
                          exp_list[i], nframe_list[i]);
                cur_word = exp_list[i];
            end else begin
                $display("unknown stimulus operation %s on line %0d", op_list[i], i);
                error_count++;
            end
            if (error_count == errors_before) begin
                pass_tests++;
                $display("test %0d %s: pass", i, op_list[i]);
            end else begin
                fail_tests++;
                $display("test %0d %s: fail", i, op_list[i]);
            end
        end

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 pass_tests, fail_tests, error_count);
        if (fail_tests == 0 && error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // budget grows with the number of stimulus lines
    initial begin
        wait (ops_loaded);
        #((op_list.size() + 2) * CYCLES_PER_OP * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/dac_stim.txt
# columns: op arg_a arg_b expected_word frames (hex, hex, hex, hex, decimal)
# BURST: arg_a = strobe count, arg_b = last level code
WAITF 0 0 1540 1
SETEN 1 0 0000 0
READ 2 0 0001 0
WRITE 1 0ab5 0ab5 1
READ 1 0 0ab5 0
LEVEL 7e 0 0ab5 0
READ 1 0 0ab5 0
READ 0 0 0001 0
READ 3 0 0000 0
SETEN 0 0 0000 0
READ 2 0 0000 0
LEVEL 3c 0 0f35 1
READ 1 0 0f35 0
WRITE 1 ffff 0f35 0
READ 1 0 0f35 0
BURST 5 a5 2975 2
READ 1 0 2975 0
SETEN 1 0 0000 0
WRITE 1 8000 8000 1
READ 1 0 8000 0
WRITE 0 1234 8000 0
READ 0 0 0001 0

//--- dac_ad5601_top.f
verilog/dac_pkg.sv
verilog/dac_frame_if.sv
verilog/dac_reg_map.sv
verilog/dac_update_sequencer.sv
verilog/sclk_bit_timer.sv
verilog/dac_serial_shifter.sv
verilog/dac_ad5601_top.sv
sim/dac_ad5601_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DAC controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f dac_ad5601_top.f --top-module dac_ad5601_tb \
        -o dac_ad5601_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/dac_ad5601_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -qF '*** FAILED ***' "$LOG"; then
    exit 1
fi
exit 0
